//--- i2c_master.f
rtl/i2c_bus_pkg.sv
rtl/oled_txn_pkg.sv
rtl/i2c_bit_engine.sv
rtl/oled_txn_ctrl.sv
rtl/i2c_master.sv
sim/i2c_slave_model.sv
sim/tb_i2c_master.sv

//--- Makefile
TOP := tb_i2c_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns \
		-f i2c_master.f --top-module $(TOP)

sim:
	verilator --binary --assert --timescale 1ns/1ns \
		-f i2c_master.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- sim/tb_i2c_master.sv
`timescale 1ns/1ns

module tb_i2c_master
    import i2c_bus_pkg::*;
    import oled_txn_pkg::*;
();

    logic        CLK;
    logic        NRST;
    logic        scl_tick = 1'b0;
    logic [1:0]  tick_div = 2'd0;
    logic        start;
    txn_req_t    req;
    logic        scl_pull;
    logic        sda_pull;
    logic        busy;
    logic        done;
    logic        nack;
    count_t      cmd_count;
    count_t      data_count;

    logic        scl;
    logic        sda;
    logic        slv_scl_pull;
    logic        slv_sda_pull;
    logic [7:0]  nack_index;
    logic [7:0]  stretch_clks;
    logic        slv_in_txn;
    logic [7:0]  slv_nbytes;
    byte_t [3:0] slv_cap;
    logic [7:0]  slv_txn_cnt;
    int          slv_bus_errs;

    logic [31:0] rng;
    int          value_errs;
    int          timeouts;
    txn_req_t    r;
    txn_req_t    r_late;
    count_t      exp_cmd;    // acked commands so far
    count_t      exp_data;   // acked data bytes so far

    // wired-AND bus with pull-ups
    assign scl = !(scl_pull || slv_scl_pull);
    assign sda = !(sda_pull || slv_sda_pull);

    i2c_master i_i2c_master (
        .CLK        (CLK),
        .NRST       (NRST),
        .scl_tick   (scl_tick),
        .start      (start),
        .req        (req),
        .scl_in     (scl),
        .sda_in     (sda),
        .scl_pull   (scl_pull),
        .sda_pull   (sda_pull),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .cmd_count  (cmd_count),
        .data_count (data_count)
    );

    i2c_slave_model #(.ADDR(7'h3C)) i_slave (
        .CLK          (CLK),
        .NRST         (NRST),
        .scl          (scl),
        .sda          (sda),
        .nack_index   (nack_index),
        .stretch_clks (stretch_clks),
        .scl_pull     (slv_scl_pull),
        .sda_pull     (slv_sda_pull),
        .in_txn       (slv_in_txn),
        .nbytes       (slv_nbytes),
        .cap          (slv_cap),
        .txn_cnt      (slv_txn_cnt),
        .bus_errs     (slv_bus_errs)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // one tick every 4 clocks
    always @(negedge CLK) begin
        tick_div <= tick_div + 2'd1;
        scl_tick <= (tick_div == 2'd3);
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic txn_req_t make_request(input slave_addr_t addr);
        txn_req_t    t;
        logic [31:0] rnd;
        rnd          = next_rand();
        t.slave_addr = addr;
        t.is_data    = rnd[0];
        t.payload    = rnd[15:8];
        return t;
    endfunction

    task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        while (busy !== 1'b1 && cycles < 20) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy !== 1'b1) begin
            timeouts++;
            $display("timeout: busy did not rise after start at %0t", $time);
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < 2000) begin
            @(negedge CLK);
            cycles++;
        end
        if (done !== 1'b1) begin
            timeouts++;
            $display("timeout: done did not pulse within 2000 clocks at %0t", $time);
        end
    endtask

    // t_late replaces req while start is still high and the master is busy
    task automatic send_request(input txn_req_t t, input txn_req_t t_late, input int hold_clks);
        @(negedge CLK);
        req   = t;
        start = 1'b1;
        wait_busy();
        req = t_late;
        repeat (hold_clks) @(negedge CLK);
        start = 1'b0;
    endtask

    task automatic run_acked(input txn_req_t t, input txn_req_t t_late, input int hold_clks);
        logic [7:0] txn0;
        txn0 = slv_txn_cnt;
        if (t.is_data) begin
            exp_data = exp_data + 8'd1;
        end else begin
            exp_cmd = exp_cmd + 8'd1;
        end
        send_request(t, t_late, hold_clks);
        wait_done();
        check_eq("busy", {7'h0, busy}, 8'h00);
        check_eq("slv_nbytes", slv_nbytes, 8'd3);
        check_eq("slv_cap[0]", slv_cap[0], {t.slave_addr, 1'b0});
        check_eq("slv_cap[1]", slv_cap[1], t.is_data ? 8'h40 : 8'h00);
        check_eq("slv_cap[2]", slv_cap[2], t.payload);
        check_eq("nack", {7'h0, nack}, 8'h00);
        check_eq("slv_in_txn", {7'h0, slv_in_txn}, 8'h00);
        check_eq("slv_txn_cnt", slv_txn_cnt, txn0 + 8'd1);
        check_eq("cmd_count", cmd_count, exp_cmd);
        check_eq("data_count", data_count, exp_data);
    endtask

    task automatic run_nacked(input txn_req_t t, input logic [7:0] exp_nbytes);
        logic [7:0] txn0;
        txn0 = slv_txn_cnt;
        send_request(t, t, 0);
        wait_done();
        check_eq("busy", {7'h0, busy}, 8'h00);
        check_eq("slv_nbytes", slv_nbytes, exp_nbytes); // no bytes after the refused one
        check_eq("slv_cap[0]", slv_cap[0], {t.slave_addr, 1'b0});
        check_eq("nack", {7'h0, nack}, 8'h01);
        check_eq("slv_in_txn", {7'h0, slv_in_txn}, 8'h00);
        check_eq("slv_txn_cnt", slv_txn_cnt, txn0 + 8'd1);
        check_eq("cmd_count", cmd_count, exp_cmd);
        check_eq("data_count", data_count, exp_data);
    endtask

    initial begin
        NRST         = 1'b0;
        start        = 1'b0;
        req          = '0;
        nack_index   = 8'hFF;
        stretch_clks = 8'd0;
        rng          = 32'd99;
        value_errs   = 0;
        timeouts     = 0;
        exp_cmd      = '0;
        exp_data     = '0;
        repeat (4) @(negedge CLK);
        NRST = 1'b1;

        check_eq("scl_pull", {7'h0, scl_pull}, 8'h00);
        check_eq("sda_pull", {7'h0, sda_pull}, 8'h00);
        check_eq("busy", {7'h0, busy}, 8'h00);
        check_eq("done", {7'h0, done}, 8'h00);
        check_eq("nack", {7'h0, nack}, 8'h00);
        check_eq("cmd_count", cmd_count, 8'h00);
        check_eq("data_count", data_count, 8'h00);

        // random commands and data with every third one stretched at STOP
        for (int i = 0; i < 9; i++) begin
            r            = make_request(7'h3C);
            stretch_clks = (i % 3 == 2) ? 8'd40 : 8'd0;
            run_acked(r, r, 0);
        end
        stretch_clks = 8'd0;

        run_nacked(make_request(7'h3D), 8'd1); // nobody at this address
        nack_index = 8'd1;
        run_nacked(make_request(7'h3C), 8'd2); // control byte refused
        nack_index = 8'hFF;

        // start stays high while busy with another request on req
        r              = make_request(7'h3C);
        r_late         = r;
        r_late.is_data = !r.is_data;
        r_late.payload = ~r.payload;
        run_acked(r, r_late, 30);

        repeat (10) @(negedge CLK);
        // no queued request may follow once the bus went quiet
        check_eq("busy", {7'h0, busy}, 8'h00);
        check_eq("slv_in_txn", {7'h0, slv_in_txn}, 8'h00);
        check_eq("slv_txn_cnt", slv_txn_cnt, 8'd12); // 9 random, 2 refused, 1 held start

        $display("errors: %0d wrong values, %0d bus protocol, %0d timeouts",
                 value_errs, slv_bus_errs, timeouts);
        if (value_errs == 0 && slv_bus_errs == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/i2c_slave_model.sv
`timescale 1ns/1ns

module i2c_slave_model
    import i2c_bus_pkg::*;
#(
    parameter logic [6:0] ADDR = 7'h3C
) (
    input  logic        CLK,
    input  logic        NRST,
    input  logic        scl,           // resolved bus levels
    input  logic        sda,
    input  logic [7:0]  nack_index,    // byte slot answered with NACK, 8'hFF for none
    input  logic [7:0]  stretch_clks,  // SCL held low after the payload ack
    output logic        scl_pull,      // 1 pulls the line low
    output logic        sda_pull,
    output logic        in_txn,
    output logic [7:0]  nbytes,        // bytes seen since START
    output byte_t [3:0] cap,
    output logic [7:0]  txn_cnt,       // STOPs seen
    output int          bus_errs
);

    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;  // SCL pulses in this slot, 9 with the ack
    byte_t      shreg;
    logic       addressed;
    logic       ack_now;
    logic [7:0] stretch_left;
    logic       start_cond;
    logic       stop_cond;

    // SDA moving while SCL stays high
    assign start_cond = scl_q && scl && sda_q && !sda;
    assign stop_cond  = scl_q && scl && !sda_q && sda;

    assign ack_now  = (nbytes == 8'd0) ? (shreg == {ADDR, 1'b0})
                                       : (addressed && (nbytes != nack_index));
    assign scl_pull = (stretch_left != 8'd0);

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            in_txn       <= 1'b0;
            bit_cnt      <= '0;
            nbytes       <= '0;
            shreg        <= '0;
            addressed    <= 1'b0;
            stretch_left <= '0;
            sda_pull     <= 1'b0;
            cap          <= '0;
            txn_cnt      <= '0;
            bus_errs     <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (stretch_left != 8'd0) begin
                stretch_left <= stretch_left - 8'd1;
            end
            if (start_cond) begin
                if (in_txn) begin
                    bus_errs <= bus_errs + 1;
                    $display("slave: SDA fell while SCL high inside a transaction at %0t", $time);
                end
                in_txn    <= 1'b1;
                bit_cnt   <= '0;
                nbytes    <= '0;
                addressed <= 1'b0;
            end else if (stop_cond) begin
                // STOP comes after the first SCL rise of a fresh slot
                if (!in_txn || bit_cnt > 4'd1) begin
                    bus_errs <= bus_errs + 1;
                    $display("slave: SDA rose while SCL high away from a byte boundary at %0t",
                             $time);
                end
                in_txn  <= 1'b0;
                txn_cnt <= txn_cnt + 8'd1;
            end else if (scl && !scl_q) begin
                if (!in_txn) begin
                    bus_errs <= bus_errs + 1;
                    $display("slave: SCL pulse with no START before it at %0t", $time);
                end else begin
                    if (bit_cnt < 4'd8) begin
                        shreg <= {shreg[6:0], sda}; // msb first
                    end
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (!scl && scl_q && in_txn) begin
                if (bit_cnt == 4'd8) begin
                    if (nbytes < 8'd4) begin
                        cap[nbytes[1:0]] <= shreg;
                    end else begin
                        bus_errs <= bus_errs + 1;
                        $display("slave: more bytes than one transaction holds at %0t", $time);
                    end
                    nbytes   <= nbytes + 8'd1;
                    sda_pull <= ack_now;
                    if (nbytes == 8'd0) begin
                        addressed <= ack_now;
                    end
                end else if (bit_cnt == 4'd9) begin
                    sda_pull <= 1'b0; // end of ack slot
                    bit_cnt  <= '0;
                    if (nbytes == 8'd3 && sda_pull) begin
                        stretch_left <= stretch_clks;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/i2c_master.sv
`timescale 1ns/1ns

module i2c_master
    import i2c_bus_pkg::*;
    import oled_txn_pkg::*;
(
    input  logic     CLK,
    input  logic     NRST,
    input  logic     scl_tick,   // one clock pulse at 4x bit rate
    input  logic     start,
    input  txn_req_t req,
    input  logic     scl_in,     // wired-AND readback
    input  logic     sda_in,
    output logic     scl_pull,   // open drain, high pulls low
    output logic     sda_pull,
    output logic     busy,
    output logic     done,
    output logic     nack,
    output count_t   cmd_count,
    output count_t   data_count
);

    symbol_e sym;
    byte_t   tx_byte;
    logic    sym_done;
    logic    ack_ok;

    // address, control and payload sequencing
    oled_txn_ctrl i_oled_txn_ctrl (
        .CLK        (CLK),
        .NRST       (NRST),
        .start      (start),
        .req        (req),
        .sym_done   (sym_done),
        .ack_ok     (ack_ok),
        .sym        (sym),
        .tx_byte    (tx_byte),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .cmd_count  (cmd_count),
        .data_count (data_count)
    );

    // line level timing
    i2c_bit_engine i_i2c_bit_engine (
        .CLK      (CLK),
        .NRST     (NRST),
        .scl_tick (scl_tick),
        .sym      (sym),
        .tx_byte  (tx_byte),
        .sda_in   (sda_in),
        .scl_in   (scl_in),
        .sym_done (sym_done),
        .ack_ok   (ack_ok),
        .scl_pull (scl_pull),
        .sda_pull (sda_pull)
    );

endmodule

//--- rtl/oled_txn_ctrl.sv
`timescale 1ns/1ns

module oled_txn_ctrl
    import i2c_bus_pkg::*;
    import oled_txn_pkg::*;
(
    input  logic       CLK,
    input  logic       NRST,
    input  logic       start,      // level, taken while idle
    input  txn_req_t   req,
    input  logic       sym_done,
    input  logic       ack_ok,
    output symbol_e    sym,
    output byte_t      tx_byte,
    output logic       busy,
    output logic       done,
    output logic       nack,
    output count_t     cmd_count,
    output count_t     data_count
);

    txn_state_e state;
    txn_req_t   req_q;
    logic       accept;

    assign accept = (state == ST_IDLE) && start;

    // request held for the whole transaction
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // symbol and byte follow the state directly
    always_comb begin
        sym     = SYM_NONE;
        tx_byte = '0;
        case (state)
            ST_START: sym = SYM_START;
            ST_ADDR: begin
                sym     = SYM_BYTE;
                tx_byte = {req_q.slave_addr, ADDR_WRITE_BIT};
            end
            ST_CTRL: begin
                sym     = SYM_BYTE;
                tx_byte = req_q.is_data ? CTRL_DATA : CTRL_CMD;
            end
            ST_PAYLOAD: begin
                sym     = SYM_BYTE;
                tx_byte = req_q.payload;
            end
            ST_STOP: sym = SYM_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            done       <= 1'b0;
            nack       <= 1'b0;
            cmd_count  <= '0;
            data_count <= '0;
        end else begin
            done <= 1'b0; // single clock pulse
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_START;
                        busy  <= 1'b1;
                        nack  <= 1'b0; // previous result dropped here
                    end
                end
                ST_START: begin
                    if (sym_done) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (sym_done) begin
                        if (ack_ok) begin
                            state <= ST_CTRL;
                        end else begin
                            state <= ST_STOP; // nobody at this address
                            nack  <= 1'b1;
                        end
                    end
                end
                ST_CTRL: begin
                    if (sym_done) begin
                        if (ack_ok) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            state <= ST_STOP;
                            nack  <= 1'b1;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (sym_done) begin
                        state <= ST_STOP;
                        if (!ack_ok) begin
                            nack <= 1'b1;
                        end else if (req_q.is_data) begin
                            data_count <= data_count + count_t'(1);
                        end else begin
                            cmd_count <= cmd_count + count_t'(1);
                        end
                    end
                end
                ST_STOP: begin
                    // may take longer when the slave stretches SCL
                    if (sym_done) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // done only once the bit engine has gone quiet
    a_done_idle_bus: assert property (
        @(posedge CLK) disable iff (!NRST)
        done |-> (sym == SYM_NONE)
    );

    // busy tracks the state register across accept and stop
    a_busy_state: assert property (
        @(posedge CLK) disable iff (!NRST)
        (state == ST_IDLE) |-> !busy
    );

endmodule

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ns

module i2c_bit_engine
    import i2c_bus_pkg::*;
(
    input  logic    CLK,
    input  logic    NRST,
    input  logic    scl_tick,  // 4x bit rate
    input  symbol_e sym,
    input  byte_t   tx_byte,
    input  logic    sda_in,    // resolved bus level
    input  logic    scl_in,
    output logic    sym_done,
    output logic    ack_ok,
    output logic    scl_pull,  // 1 pulls the line low
    output logic    sda_pull
);

    bit_phase_e phase;
    bit_cnt_t   bit_cnt;
    byte_t      shift;
    logic       active;  // a symbol is in progress
    logic       ack_q;
    logic       data_bit;
    logic       last_bit;

    // first tick of a byte still sees tx_byte, shift is loaded on that tick
    assign data_bit = active ? shift[7] : tx_byte[7];
    assign last_bit = (sym != SYM_BYTE) || (bit_cnt == '0);

    // end of symbol on its last tick, so the sequencer moves on at the same edge
    assign sym_done = scl_tick && active && (phase == PH_FALL) && last_bit;
    assign ack_ok   = ack_q;

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            phase    <= PH_SET;
            bit_cnt  <= bit_cnt_t'(BYTE_BITS);
            active   <= 1'b0;
            ack_q    <= 1'b0;
            scl_pull <= 1'b0;
            sda_pull <= 1'b0;
        end else if (!active && sym == SYM_NONE) begin
            // bus idle, let both lines float high
            scl_pull <= 1'b0;
            sda_pull <= 1'b0;
        end else if (scl_tick) begin
            active <= 1'b1;
            case (phase)
                PH_SET: begin
                    phase <= PH_RISE;
                    case (sym)
                        SYM_START: sda_pull <= 1'b1; // SDA falls, SCL still high
                        SYM_BYTE: begin
                            if (!active) begin
                                shift <= tx_byte;
                            end
                            // ack slot releases SDA for the slave
                            sda_pull <= (bit_cnt != '0) && !data_bit;
                        end
                        SYM_STOP:  sda_pull <= 1'b1; // SDA low before SCL goes up
                        default: ;
                    endcase
                end
                PH_RISE: begin
                    phase <= PH_HIGH;
                    if (sym == SYM_BYTE || sym == SYM_STOP) begin
                        scl_pull <= 1'b0;
                    end
                end
                PH_HIGH: begin
                    phase <= PH_FALL;
                    case (sym)
                        SYM_START: scl_pull <= 1'b1;
                        SYM_BYTE: begin
                            if (bit_cnt == '0) begin
                                ack_q <= !sda_in; // low means ack
                            end
                        end
                        SYM_STOP: begin
                            // slave may still hold SCL low, wait for it
                            if (scl_in) begin
                                sda_pull <= 1'b0; // SDA rises while SCL high
                            end else begin
                                phase <= PH_HIGH;
                            end
                        end
                        default: ;
                    endcase
                end
                PH_FALL: begin
                    phase <= PH_SET;
                    if (sym == SYM_BYTE) begin
                        scl_pull <= 1'b1;
                        shift    <= {shift[6:0], 1'b0};
                    end
                    if (last_bit) begin
                        active  <= 1'b0;
                        bit_cnt <= bit_cnt_t'(BYTE_BITS); // ready for next byte
                    end else begin
                        bit_cnt <= bit_cnt - bit_cnt_t'(1);
                    end
                end
            endcase
        end
    end

    // bus timing only moves with the external tick
    a_phase_on_tick: assert property (
        @(posedge CLK) disable iff (!NRST)
        (phase != $past(phase)) |-> $past(scl_tick)
    );

    // data is stable while SCL is high, START and STOP are the only exceptions
    a_sda_stable: assert property (
        @(posedge CLK) disable iff (!NRST)
        ((sda_pull != $past(sda_pull)) && $past(scl_in))
            |-> (($past(sym) == SYM_START) || ($past(sym) == SYM_STOP))
    );

endmodule

//--- rtl/oled_txn_pkg.sv
package oled_txn_pkg;

    import i2c_bus_pkg::byte_t;

    // 7-bit i2c slave address
    typedef logic [6:0] slave_addr_t;

    // acked byte counters, free running
    typedef logic [7:0] count_t;

    // one display write request
    typedef struct packed {
        slave_addr_t slave_addr;
        logic        is_data;    // D/C: 1 for gddram data, 0 for command
        byte_t       payload;
    } txn_req_t;

    // sequencer states, one per symbol on the bus
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_START   = 3'd1,
        ST_ADDR    = 3'd2, // address with write bit
        ST_CTRL    = 3'd3, // control byte
        ST_PAYLOAD = 3'd4, // command or data byte
        ST_STOP    = 3'd5
    } txn_state_e;

    // control byte, Co = 0 so only one payload byte follows
    localparam byte_t CTRL_CMD  = 8'h00;
    localparam byte_t CTRL_DATA = 8'h40; // D/C set

    // R/W# bit of the address byte, always write
    localparam logic ADDR_WRITE_BIT = 1'b0;

endpackage

//--- rtl/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // one byte as shifted onto SDA
    typedef logic [7:0] byte_t;

    // bits left in a byte slot, 8 data bits down to the ack bit at 0
    typedef logic [3:0] bit_cnt_t;

    // quarter phases of one bit on the wire
    typedef enum logic [1:0] {
        PH_SET  = 2'd0, // put data on SDA while SCL is low
        PH_RISE = 2'd1, // let SCL go high
        PH_HIGH = 2'd2, // SCL high, sample or hold
        PH_FALL = 2'd3  // pull SCL low again
    } bit_phase_e;

    // what the sequencer asks the bit engine to put on the bus
    typedef enum logic [1:0] {
        SYM_NONE  = 2'd0, // idle, both lines released
        SYM_START = 2'd1,
        SYM_BYTE  = 2'd2, // 8 data bits plus ack slot
        SYM_STOP  = 2'd3
    } symbol_e;

    localparam int BYTE_BITS = 8;

endpackage
